/* source/opl_pkg.sv */
/*
 * opl host front end shared definitions
 * register indexes, host window addresses, management map,
 * timer widths and prescale shifts
 */

package opl_pkg;

    // chip register space, bit 8 picks the high bank
    localparam int INDEX_W   = 9;
    localparam int REG_COUNT = 512;

    // timer registers in the low bank
    localparam logic [INDEX_W-1:0] REG_TIMER1     = 9'd2;
    localparam logic [INDEX_W-1:0] REG_TIMER2     = 9'd3;
    localparam logic [INDEX_W-1:0] REG_TIMER_CTRL = 9'd4;

    // sound-card window, 16 addresses
    localparam logic [3:0] SB_ADDR_INDEX_LO = 4'd8;
    localparam logic [3:0] SB_ADDR_DATA     = 4'd1;
    localparam logic [3:0] SB_ADDR_DATA_ALT = 4'd9;
    localparam logic [3:0] SB_ADDR_INDEX_HI = 4'd2;
    localparam logic [3:0] SB_ADDR_DATA_HI  = 4'd3;

    // fm-only window, 4 addresses
    localparam logic [1:0] FM_ADDR_INDEX_LO = 2'd0;
    localparam logic [1:0] FM_ADDR_DATA     = 2'd1;
    localparam logic [1:0] FM_ADDR_INDEX_HI = 2'd2;
    localparam logic [1:0] FM_ADDR_DATA_HI  = 2'd3;

    // management map
    localparam logic [8:0] MGMT_ADDR_PERIOD = 9'd256;

    // base period and timer resolution
    localparam int PERIOD_W = 13;
    localparam int RES_W    = 15;

    // status id bits reported outside opl3 mode
    localparam logic [4:0] CHIP_ID_OPL2 = 5'd6;

    // timer 2 runs four times slower than timer 1
    localparam int TIMER1_SHIFT = 0;
    localparam int TIMER2_SHIFT = 2;

endpackage

/* source/opl_timer.sv */
/*
 * opl interval timer
 * 8-bit up counter clocked by a prescaler of period << SHIFT,
 * pulses for one cycle on wrap and reloads the preset
 */

`timescale 1ns/10ps

module opl_timer #(
    parameter int SHIFT = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [opl_pkg::PERIOD_W-1:0] period,
    input  logic [7:0]                   preset,
    input  logic                         run,
    output logic                         overflow_pulse
);

    logic [opl_pkg::RES_W-1:0] resolution;
    logic [opl_pkg::RES_W-1:0] sub_counter;
    logic [7:0]                counter;
    logic                      run_q;
    logic                      run_rise;

    // widen period then scale by the prescale shift
    assign resolution = {{(opl_pkg::RES_W - opl_pkg::PERIOD_W){1'b0}}, period} << SHIFT;

    // start edge loads both counters
    assign run_rise = run && !run_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q          <= 1'b0;
            counter        <= '0;
            sub_counter    <= '0;
            overflow_pulse <= 1'b0;
        end else begin
            run_q          <= run;
            overflow_pulse <= 1'b0;
            if (run_rise) begin
                counter     <= preset;
                sub_counter <= resolution;
            end else if (run) begin
                if (sub_counter == '0) begin
                    // one tick of the main counter
                    sub_counter <= resolution;
                    if (counter == 8'hFF) begin
                        // wrap: pulse and restart from preset
                        overflow_pulse <= 1'b1;
                        counter        <= preset;
                    end else begin
                        counter <= counter + 8'd1;
                    end
                end else begin
                    sub_counter <= sub_counter - 1'b1;
                end
            end
            // stopped timer holds its count
        end
    end

endmodule

/* source/opl_timer_ctrl.sv */
/*
 * opl timer control
 * timer presets, mask and run bits, sticky overflow flags,
 * management base period register and both interval timers
 */

`timescale 1ns/10ps

module opl_timer_ctrl #(
    parameter int unsigned PERIOD_RESET = 2400
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // chip register writes from the host port
    input  logic [opl_pkg::INDEX_W-1:0] index,
    input  logic                        io_write,
    input  logic [7:0]                  io_writedata,

    // management port
    input  logic [8:0]                  mgmt_address,
    input  logic                        mgmt_write,
    input  logic [31:0]                 mgmt_writedata,

    // sticky flags to the status byte
    output logic                        timer1_overflow,
    output logic                        timer2_overflow
);

    // reset value cut to the period field
    localparam logic [opl_pkg::PERIOD_W-1:0] PERIOD_INIT =
        PERIOD_RESET[opl_pkg::PERIOD_W-1:0];

    logic [opl_pkg::PERIOD_W-1:0] period;
    logic [7:0]                   timer1_preset;
    logic [7:0]                   timer2_preset;
    logic                         ctrl_write;
    logic                         flag_clear;
    // bit 0 is timer 1, bit 1 is timer 2
    logic [1:0]                   mask;
    logic [1:0]                   run;
    logic [1:0]                   pulse;
    logic [1:0]                   flags;

    // base period, cycles in one timer 1 tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period <= PERIOD_INIT;
        end else if (mgmt_write && mgmt_address == opl_pkg::MGMT_ADDR_PERIOD) begin
            period <= mgmt_writedata[opl_pkg::PERIOD_W-1:0];
        end
    end

    // preset registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer1_preset <= '0;
            timer2_preset <= '0;
        end else if (io_write) begin
            if (index == opl_pkg::REG_TIMER1) begin
                timer1_preset <= io_writedata;
            end
            if (index == opl_pkg::REG_TIMER2) begin
                timer2_preset <= io_writedata;
            end
        end
    end

    // control register, bit 7 means flag reset instead
    assign ctrl_write = io_write && (index == opl_pkg::REG_TIMER_CTRL);
    assign flag_clear = ctrl_write && io_writedata[7];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask <= '0;
            run  <= '0;
        end else if (ctrl_write && !io_writedata[7]) begin
            mask <= {io_writedata[5], io_writedata[6]};
            run  <= {io_writedata[1], io_writedata[0]};
        end
    end

    // sticky flags
    // an unmasked pulse beats a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else begin
            flags <= (flag_clear ? 2'b00 : flags) | (pulse & ~mask);
        end
    end

    assign timer1_overflow = flags[0];
    assign timer2_overflow = flags[1];

    // timer 1 at the base period
    opl_timer #(
        .SHIFT (opl_pkg::TIMER1_SHIFT)
    ) u_timer1 (
        .clk            (clk),
        .rst_n          (rst_n),
        .period         (period),
        .preset         (timer1_preset),
        .run            (run[0]),
        .overflow_pulse (pulse[0])
    );

    // timer 2 at four base periods
    opl_timer #(
        .SHIFT (opl_pkg::TIMER2_SHIFT)
    ) u_timer2 (
        .clk            (clk),
        .rst_n          (rst_n),
        .period         (period),
        .preset         (timer2_preset),
        .run            (run[1]),
        .overflow_pulse (pulse[1])
    );

endmodule

/* source/opl_host_port.sv */
/*
 * opl host port
 * decodes the sound-card and fm i/o windows, keeps the 9-bit
 * register index, forms the data write strobe and returns the
 * timer status byte on reads
 */

`timescale 1ns/10ps

module opl_host_port (
    input  logic                        clk,
    input  logic                        rst_n,

    // sound-card window
    input  logic [3:0]                  sb_address,
    input  logic                        sb_write,
    input  logic [7:0]                  sb_writedata,
    output logic [7:0]                  sb_readdata,

    // fm window
    input  logic [1:0]                  fm_address,
    input  logic                        fm_write,
    input  logic [7:0]                  fm_writedata,
    output logic [7:0]                  fm_readdata,
    input  logic                        fm_mode,

    // flags from timer control
    input  logic                        timer1_overflow,
    input  logic                        timer2_overflow,

    // chip register write side
    output logic [opl_pkg::INDEX_W-1:0] index,
    output logic                        io_write,
    output logic [7:0]                  io_writedata
);

    logic       sb_index_lo;
    logic       sb_index_hi;
    logic       fm_index_lo;
    logic       fm_index_hi;
    logic       sb_data;
    logic       fm_data;
    logic [4:0] status_id;
    logic [7:0] status;

    // index address hits, high bank only in opl3 mode
    assign sb_index_lo = sb_write && (sb_address == opl_pkg::SB_ADDR_INDEX_LO);
    assign sb_index_hi = sb_write && fm_mode && (sb_address == opl_pkg::SB_ADDR_INDEX_HI);
    assign fm_index_lo = fm_write && (fm_address == opl_pkg::FM_ADDR_INDEX_LO);
    assign fm_index_hi = fm_write && fm_mode && (fm_address == opl_pkg::FM_ADDR_INDEX_HI);

    // data address hits
    assign sb_data = sb_write && ((sb_address == opl_pkg::SB_ADDR_DATA) ||
                                  (sb_address == opl_pkg::SB_ADDR_DATA_ALT) ||
                                  (fm_mode && sb_address == opl_pkg::SB_ADDR_DATA_HI));
    assign fm_data = fm_write && ((fm_address == opl_pkg::FM_ADDR_DATA) ||
                                  (fm_mode && fm_address == opl_pkg::FM_ADDR_DATA_HI));

    // index register
    // sound-card window wins over fm window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index <= '0;
        end else if (sb_index_lo) begin
            index <= {1'b0, sb_writedata};
        end else if (sb_index_hi) begin
            index <= {1'b1, sb_writedata};
        end else if (fm_index_lo) begin
            index <= {1'b0, fm_writedata};
        end else if (fm_index_hi) begin
            index <= {1'b1, fm_writedata};
        end
    end

    // one strobe for both windows
    assign io_write     = sb_data || fm_data;
    // sound-card data whenever that bus writes
    assign io_writedata = sb_write ? sb_writedata : fm_writedata;

    // status byte: irq, t1, t2, id
    // opl3 reports zero id
    assign status_id = fm_mode ? 5'd0 : opl_pkg::CHIP_ID_OPL2;
    assign status    = {timer1_overflow | timer2_overflow,
                        timer1_overflow,
                        timer2_overflow,
                        status_id};

    // status only at the index addresses, open bus elsewhere
    assign sb_readdata = (sb_address == opl_pkg::SB_ADDR_INDEX_LO) ? status : 8'hFF;
    assign fm_readdata = (fm_address == opl_pkg::FM_ADDR_INDEX_LO) ? status : 8'hFF;

endmodule

/* source/opl_reg_file.sv */
/*
 * opl chip register file
 * 512 byte registers, written from the host port at the
 * current index, read combinationally by the synthesis core
 */

`timescale 1ns/10ps

module opl_reg_file (
    input  logic                        clk,
    input  logic                        rst_n,

    // host write side
    input  logic [opl_pkg::INDEX_W-1:0] index,
    input  logic                        io_write,
    input  logic [7:0]                  io_writedata,

    // synthesis core read side
    input  logic [opl_pkg::INDEX_W-1:0] synth_addr,
    output logic [7:0]                  synth_data
);

    // low bank 0..255, high bank 256..511
    logic [7:0] regs [opl_pkg::REG_COUNT];

    // chip registers start from zero so all voices are silent
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: 8'd0};
        end else if (io_write) begin
            // index is full width, every entry reachable
            regs[index] <= io_writedata;
        end
    end

    // asynchronous read
    // new data shows the cycle after the write strobe
    assign synth_data = regs[synth_addr];

endmodule

/* source/opl_top.sv */
/*
 * opl host front end top
 * host windows, timers and chip register file, with a register
 * read port for an attached synthesis core
 */

`timescale 1ns/10ps

module opl_top #(
    parameter int unsigned PERIOD_RESET = 2400
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // sound-card window
    input  logic [3:0]                  sb_address,
    input  logic                        sb_read,
    output logic [7:0]                  sb_readdata,
    input  logic                        sb_write,
    input  logic [7:0]                  sb_writedata,

    // fm window
    input  logic [1:0]                  fm_address,
    input  logic                        fm_read,
    output logic [7:0]                  fm_readdata,
    input  logic                        fm_write,
    input  logic [7:0]                  fm_writedata,
    input  logic                        fm_mode,

    // management port, address 256 holds the base period
    input  logic [8:0]                  mgmt_address,
    input  logic                        mgmt_write,
    input  logic [31:0]                 mgmt_writedata,

    // register read port for the synthesis core
    input  logic [opl_pkg::INDEX_W-1:0] synth_addr,
    output logic [7:0]                  synth_data
);

    // sb_read and fm_read are accepted but reads have no side effect

    logic [opl_pkg::INDEX_W-1:0] index;
    logic                        io_write;
    logic [7:0]                  io_writedata;
    logic                        timer1_overflow;
    logic                        timer2_overflow;

    opl_host_port u_host_port (
        .clk             (clk),
        .rst_n           (rst_n),
        .sb_address      (sb_address),
        .sb_write        (sb_write),
        .sb_writedata    (sb_writedata),
        .sb_readdata     (sb_readdata),
        .fm_address      (fm_address),
        .fm_write        (fm_write),
        .fm_writedata    (fm_writedata),
        .fm_readdata     (fm_readdata),
        .fm_mode         (fm_mode),
        .timer1_overflow (timer1_overflow),
        .timer2_overflow (timer2_overflow),
        .index           (index),
        .io_write        (io_write),
        .io_writedata    (io_writedata)
    );

    opl_timer_ctrl #(
        .PERIOD_RESET (PERIOD_RESET)
    ) u_timer_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .index           (index),
        .io_write        (io_write),
        .io_writedata    (io_writedata),
        .mgmt_address    (mgmt_address),
        .mgmt_write      (mgmt_write),
        .mgmt_writedata  (mgmt_writedata),
        .timer1_overflow (timer1_overflow),
        .timer2_overflow (timer2_overflow)
    );

    opl_reg_file u_reg_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .index        (index),
        .io_write     (io_write),
        .io_writedata (io_writedata),
        .synth_addr   (synth_addr),
        .synth_data   (synth_data)
    );

endmodule

/* verification/opl_tb.sv */
/*
 * opl front end testbench
 * random host writes against a register model, status readback,
 * timer overflow timing, masking, flag clear and reset of the period
 */

`timescale 1ns/10ps

module opl_tb;

    localparam int PERIOD_RESET = 2400;
    localparam int FAST_PERIOD  = 3;
    localparam int WRITE_CYCLES = 800;
    // worst timer 2 interval at the fast period
    localparam int SLOW_SPAN = 256 * ((FAST_PERIOD << opl_pkg::TIMER2_SHIFT) + 1);
    // random writes, two sweeps, six waits of one long interval, two default-period runs
    localparam int TIMEOUT_CYCLES = WRITE_CYCLES + 2 * opl_pkg::REG_COUNT + 6 * SLOW_SPAN
                                    + 2 * (PERIOD_RESET + 1) + 2000;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic [3:0]                  sb_address;
    logic                        sb_read;
    logic [7:0]                  sb_readdata;
    logic                        sb_write;
    logic [7:0]                  sb_writedata;
    logic [1:0]                  fm_address;
    logic                        fm_read;
    logic [7:0]                  fm_readdata;
    logic                        fm_write;
    logic [7:0]                  fm_writedata;
    logic                        fm_mode;
    logic [8:0]                  mgmt_address;
    logic                        mgmt_write;
    logic [31:0]                 mgmt_writedata;
    logic [opl_pkg::INDEX_W-1:0] synth_addr;
    logic [7:0]                  synth_data;

    // reference model state
    logic [7:0]                    m_regs [opl_pkg::REG_COUNT];
    logic [opl_pkg::INDEX_W-1:0]   m_index;
    logic [opl_pkg::PERIOD_W-1:0]  m_period;

    integer seed = 42;
    int     value_errors = 0;
    int     other_errors = 0;
    int     cycles = 0;

    opl_top #(
        .PERIOD_RESET (PERIOD_RESET)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .sb_address     (sb_address),
        .sb_read        (sb_read),
        .sb_readdata    (sb_readdata),
        .sb_write       (sb_write),
        .sb_writedata   (sb_writedata),
        .fm_address     (fm_address),
        .fm_read        (fm_read),
        .fm_readdata    (fm_readdata),
        .fm_write       (fm_write),
        .fm_writedata   (fm_writedata),
        .fm_mode        (fm_mode),
        .mgmt_address   (mgmt_address),
        .mgmt_write     (mgmt_write),
        .mgmt_writedata (mgmt_writedata),
        .synth_addr     (synth_addr),
        .synth_data     (synth_data)
    );

    always #5 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED t=%0t %s expected %02h actual %02h", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED t=%0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_window(input string what, input int seen, input int lo, input int hi);
        if (seen < 0) begin
            other_errors++;
            $display("%s never rose, expected after %0d to %0d cycles", what, lo, hi);
        end else if (seen < lo || seen > hi) begin
            other_errors++;
            $display("%s rose after %0d cycles, expected %0d to %0d", what, seen, lo, hi);
        end
    endtask

    // status byte {irq, t1, t2, id}
    function automatic logic [7:0] expected_status(input logic f1, input logic f2,
                                                   input logic mode);
        return {f1 | f2, f1, f2, mode ? 5'd0 : opl_pkg::CHIP_ID_OPL2};
    endfunction

    // cycles from run edge to first overflow
    function automatic int predict(input logic [7:0] preset, input int shift);
        return (256 - int'(preset)) * ((int'(m_period) << shift) + 1);
    endfunction

    // one host cycle on both windows, model follows
    task automatic bus_cycle(input logic sbw, input logic [3:0] sba, input logic [7:0] sbd,
                             input logic fmw, input logic [1:0] fma, input logic [7:0] fmd);
        logic sb_hit;
        logic fm_hit;
        @(negedge clk);
        sb_write     = sbw;
        sb_address   = sba;
        sb_writedata = sbd;
        fm_write     = fmw;
        fm_address   = fma;
        fm_writedata = fmd;
        sb_hit = sbw && (sba == opl_pkg::SB_ADDR_DATA || sba == opl_pkg::SB_ADDR_DATA_ALT ||
                         (fm_mode && sba == opl_pkg::SB_ADDR_DATA_HI));
        fm_hit = fmw && (fma == opl_pkg::FM_ADDR_DATA ||
                         (fm_mode && fma == opl_pkg::FM_ADDR_DATA_HI));
        // data goes to the index held before this cycle
        if (sb_hit || fm_hit)
            m_regs[m_index] = sbw ? sbd : fmd;
        if (sbw && sba == opl_pkg::SB_ADDR_INDEX_LO)
            m_index = {1'b0, sbd};
        else if (sbw && fm_mode && sba == opl_pkg::SB_ADDR_INDEX_HI)
            m_index = {1'b1, sbd};
        else if (fmw && fma == opl_pkg::FM_ADDR_INDEX_LO)
            m_index = {1'b0, fmd};
        else if (fmw && fm_mode && fma == opl_pkg::FM_ADDR_INDEX_HI)
            m_index = {1'b1, fmd};
    endtask

    // strobes low, status visible on both windows
    task automatic idle();
        @(negedge clk);
        sb_write   = 1'b0;
        fm_write   = 1'b0;
        mgmt_write = 1'b0;
        sb_address = opl_pkg::SB_ADDR_INDEX_LO;
        fm_address = opl_pkg::FM_ADDR_INDEX_LO;
    endtask

    // low-bank register write through the sound-card window
    task automatic reg_write(input logic [7:0] idx, input logic [7:0] data);
        bus_cycle(1'b1, opl_pkg::SB_ADDR_INDEX_LO, idx, 1'b0, 2'd0, 8'd0);
        bus_cycle(1'b1, opl_pkg::SB_ADDR_DATA, data, 1'b0, 2'd0, 8'd0);
        idle();
    endtask

    task automatic mgmt_cycle(input logic [8:0] addr, input logic [31:0] data);
        @(negedge clk);
        mgmt_address   = addr;
        mgmt_write     = 1'b1;
        mgmt_writedata = data;
        if (addr == opl_pkg::MGMT_ADDR_PERIOD)
            m_period = data[opl_pkg::PERIOD_W-1:0];
        idle();
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        foreach (m_regs[i])
            m_regs[i] = 8'd0;
        m_index  = '0;
        m_period = PERIOD_RESET[opl_pkg::PERIOD_W-1:0];
    endtask

    task automatic sweep_regs();
        for (int a = 0; a < opl_pkg::REG_COUNT; a++) begin
            @(negedge clk);
            synth_addr = a[opl_pkg::INDEX_W-1:0];
            #1;
            check_byte($sformatf("synth_data[%0d]", a), m_regs[a], synth_data);
        end
    endtask

    // first cycle each flag is seen, -1 if never
    task automatic wait_flags(input int limit, input logic need1, input logic need2,
                              output int t1_at, output int t2_at);
        logic [7:0] st;
        t1_at = -1;
        t2_at = -1;
        for (int n = 1; n <= limit; n++) begin
            @(negedge clk);
            #1;
            st = sb_readdata;
            check_flag("sb_readdata[7] irq", st[6] | st[5], st[7]);
            if (st[6] && t1_at < 0)
                t1_at = n;
            if (st[5] && t2_at < 0)
                t2_at = n;
            if ((!need1 || t1_at >= 0) && (!need2 || t2_at >= 0))
                break;
        end
    endtask

    initial begin
        int          t1_at;
        int          t2_at;
        int          d1;
        int          d2;
        logic [31:0] r;
        logic [8:0]  addr;
        rst_n = 1'b0;
        sb_address = '0;
        sb_read = 1'b0;
        sb_write = 1'b0;
        sb_writedata = '0;
        fm_address = '0;
        fm_read = 1'b0;
        fm_write = 1'b0;
        fm_writedata = '0;
        fm_mode = 1'b0;
        mgmt_address = '0;
        mgmt_write = 1'b0;
        mgmt_writedata = '0;
        synth_addr = '0;
        apply_reset();

        // random writes on both windows, opl3 mode in the second half
        for (int i = 0; i < WRITE_CYCLES; i++) begin
            // mode flips on an idle cycle, after the last opl2 write is sampled
            if (i == WRITE_CYCLES / 2) begin
                idle();
                fm_mode = 1'b1;
            end
            r = $random(seed);
            bus_cycle(r[0] | r[1], r[5:2], r[13:6], r[14], r[16:15], r[24:17]);
        end
        idle();
        sweep_regs();
        // stop timers started by random control writes, drop their flags
        reg_write(opl_pkg::REG_TIMER_CTRL[7:0], 8'h00);
        reg_write(opl_pkg::REG_TIMER_CTRL[7:0], 8'h80);

        // readback decode in both modes
        for (int m = 0; m < 2; m++) begin
            for (int a = 0; a < 16; a++) begin
                @(negedge clk);
                fm_mode = m[0];
                sb_read = 1'b1;
                fm_read = 1'b1;
                sb_address = a[3:0];
                fm_address = a[1:0];
                #1;
                check_byte("sb_readdata", (a == 8) ? expected_status(0, 0, m[0]) : 8'hFF,
                           sb_readdata);
                check_byte("fm_readdata", (a[1:0] == 0) ? expected_status(0, 0, m[0]) : 8'hFF,
                           fm_readdata);
            end
        end
        idle();
        sb_read = 1'b0;
        fm_read = 1'b0;
        fm_mode = 1'b0;

        // both timers unmasked at a short period
        mgmt_cycle(opl_pkg::MGMT_ADDR_PERIOD, FAST_PERIOD);
        r = $random(seed);
        reg_write(opl_pkg::REG_TIMER1[7:0], {1'b0, r[6:0]});
        reg_write(opl_pkg::REG_TIMER2[7:0], {1'b0, r[14:8]});
        d1 = predict(m_regs[opl_pkg::REG_TIMER1], opl_pkg::TIMER1_SHIFT);
        d2 = predict(m_regs[opl_pkg::REG_TIMER2], opl_pkg::TIMER2_SHIFT);
        reg_write(opl_pkg::REG_TIMER_CTRL[7:0], 8'h03);
        wait_flags(d2 * 11 / 10 + 8, 1'b1, 1'b1, t1_at, t2_at);
        check_window("timer 1 flag", t1_at, d1 * 9 / 10, d1 * 11 / 10);
        check_window("timer 2 flag", t2_at, d2 * 9 / 10, d2 * 11 / 10);

        // masked run, then unmask, then clear while running
        reg_write(opl_pkg::REG_TIMER_CTRL[7:0], 8'h00);
        reg_write(opl_pkg::REG_TIMER_CTRL[7:0], 8'h80);
        reg_write(opl_pkg::REG_TIMER_CTRL[7:0], 8'h63);
        wait_flags(d2 * 11 / 10 + 8, 1'b1, 1'b1, t1_at, t2_at);
        if (t1_at >= 0 || t2_at >= 0) begin
            other_errors++;
            $display("masked timer set its flag (timer 1 at %0d, timer 2 at %0d)", t1_at, t2_at);
        end
        reg_write(opl_pkg::REG_TIMER_CTRL[7:0], 8'h03);
        wait_flags(d2 * 11 / 10 + 8, 1'b1, 1'b1, t1_at, t2_at);
        check_window("unmasked timer 1 flag", t1_at, 1, d1 * 11 / 10 + 8);
        check_window("unmasked timer 2 flag", t2_at, 1, d2 * 11 / 10 + 8);
        reg_write(opl_pkg::REG_TIMER_CTRL[7:0], 8'h80);
        #1;
        check_byte("sb_readdata", expected_status(0, 0, 0), sb_readdata);
        wait_flags(d2 * 11 / 10 + 8, 1'b1, 1'b1, t1_at, t2_at);
        check_window("timer 1 flag after clear", t1_at, 1, d1 * 11 / 10 + 8);
        check_window("timer 2 flag after clear", t2_at, 1, d2 * 11 / 10 + 8);

        // other management addresses leave the period alone
        reg_write(opl_pkg::REG_TIMER_CTRL[7:0], 8'h00);
        reg_write(opl_pkg::REG_TIMER_CTRL[7:0], 8'h80);
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            addr = r[8:0];
            if (addr == opl_pkg::MGMT_ADDR_PERIOD)
                addr = 9'd255;
            mgmt_cycle(addr, $random(seed));
        end
        reg_write(opl_pkg::REG_TIMER_CTRL[7:0], 8'h01);
        wait_flags(d1 * 11 / 10 + 8, 1'b1, 1'b0, t1_at, t2_at);
        check_window("timer 1 flag after management writes", t1_at, d1 * 9 / 10, d1 * 11 / 10);

        // reset brings back the default period and clears everything
        apply_reset();
        idle();
        #1;
        check_byte("sb_readdata", expected_status(0, 0, 0), sb_readdata);
        sweep_regs();
        reg_write(opl_pkg::REG_TIMER1[7:0], 8'hFF);
        d1 = predict(m_regs[opl_pkg::REG_TIMER1], opl_pkg::TIMER1_SHIFT);
        reg_write(opl_pkg::REG_TIMER_CTRL[7:0], 8'h01);
        wait_flags(d1 * 11 / 10 + 8, 1'b1, 1'b0, t1_at, t2_at);
        check_window("timer 1 flag at default period", t1_at, d1 * 9 / 10, d1 * 11 / 10);

        $display("errors: %0d value mismatches, %0d timing or other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* all.f */
source/opl_pkg.sv
source/opl_timer.sv
source/opl_timer_ctrl.sv
source/opl_host_port.sv
source/opl_reg_file.sv
source/opl_top.sv
verification/opl_tb.sv

/* Bender.yml */
package:
  name: opl_front_end

sources:
  - files:
      - source/opl_pkg.sv
      - source/opl_timer.sv
      - source/opl_timer_ctrl.sv
      - source/opl_host_port.sv
      - source/opl_reg_file.sv
      - source/opl_top.sv
  - target: test
    files:
      - verification/opl_tb.sv
